// File: hdl/axi_pkg.sv
package axi_pkg;

	// address bus width on both AR and AW
	localparam int ADDR_W = 32;

	// burst encodings as carried on arburst/awburst
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,	// single beat, uncached traffic
		BURST_INCR  = 2'b01	// cache line fills and write-backs
	} burst_e;

	// read IDs tell the bridge where an R beat goes
	localparam logic [3:0] ID_INSTR = 4'd0;
	localparam logic [3:0] ID_DATA  = 4'd1;

	// write response code
	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: hdl/bridge_pkg.sv
package bridge_pkg;

	// one bus word, also the cache return width
	typedef logic [31:0] word_t;

	// read side sequencing
	typedef enum logic [1:0] {
		RD_IDLE,	// waiting for a cache request
		RD_ADDR,	// arvalid up
		RD_DATA	// collecting R beats
	} rd_state_e;

	// write side sequencing
	typedef enum logic [1:0] {
		WR_IDLE,	// dc_wr_rdy up
		WR_ADDR,	// awvalid up
		WR_DATA,	// streaming W beats
		WR_RESP	// waiting on B
	} wr_state_e;

endpackage

// File: hdl/axi_read_path.sv
`timescale 1ns/1ps

module axi_read_path #(
	parameter int LINE_WORDS = 16
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         ic_rd_req,
	input  logic [axi_pkg::ADDR_W-1:0]   ic_rd_addr,
	input  logic [2:0]                   ic_rd_size,
	output logic                         ic_rd_rdy,
	input  logic                         dc_rd_req,
	input  logic [axi_pkg::ADDR_W-1:0]   dc_rd_addr,
	input  logic [2:0]                   dc_rd_size,
	input  logic                         dc_uncached,
	output logic                         dc_rd_rdy,
	output logic                         ic_ret_valid,
	output logic                         ic_ret_last,
	output logic                         dc_ret_valid,
	output logic                         dc_ret_last,
	output bridge_pkg::word_t            ret_data,
	input  logic                         wr_busy,
	input  logic [axi_pkg::ADDR_W-1:0]   wr_line_addr,
	output logic [3:0]                   arid,
	output logic [axi_pkg::ADDR_W-1:0]   araddr,
	output logic [3:0]                   arlen,
	output logic [2:0]                   arsize,
	output axi_pkg::burst_e              arburst,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic [3:0]                   rid,
	input  bridge_pkg::word_t            rdata,
	input  logic                         rlast,
	input  logic                         rvalid,
	output logic                         rready
);

	// byte offset bits inside one line
	localparam int OFFS_W = $clog2(LINE_WORDS * 4);

	bridge_pkg::rd_state_e state, state_nxt;

	logic [3:0]                 req_id;
	logic [axi_pkg::ADDR_W-1:0] req_addr;
	logic [2:0]                 req_size;
	logic                       req_unc;

	logic ic_hit, dc_hit;
	logic ic_take, dc_take;
	logic r_beat;

	// a read into the line under write-back has to wait
	assign ic_hit = wr_busy &&
		(ic_rd_addr[axi_pkg::ADDR_W-1:OFFS_W] == wr_line_addr[axi_pkg::ADDR_W-1:OFFS_W]);
	assign dc_hit = wr_busy &&
		(dc_rd_addr[axi_pkg::ADDR_W-1:OFFS_W] == wr_line_addr[axi_pkg::ADDR_W-1:OFFS_W]);

	// data cache first
	assign dc_rd_rdy = (state == bridge_pkg::RD_IDLE) && !dc_hit;
	assign ic_rd_rdy = (state == bridge_pkg::RD_IDLE) && !ic_hit && !dc_rd_req;

	assign dc_take = dc_rd_req && dc_rd_rdy;
	assign ic_take = ic_rd_req && ic_rd_rdy;

	always_comb begin
		state_nxt = state;
		case (state)
			bridge_pkg::RD_IDLE: if (dc_take || ic_take) state_nxt = bridge_pkg::RD_ADDR;
			bridge_pkg::RD_ADDR: if (arready) state_nxt = bridge_pkg::RD_DATA;
			bridge_pkg::RD_DATA: if (rvalid && rlast) state_nxt = bridge_pkg::RD_IDLE;
			default:             state_nxt = bridge_pkg::RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= bridge_pkg::RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// request held steady for the whole burst
	always_ff @(posedge clk) begin
		if (dc_take) begin
			req_id   <= axi_pkg::ID_DATA;
			req_addr <= dc_rd_addr;
			req_size <= dc_rd_size;
			req_unc  <= dc_uncached;
		end else if (ic_take) begin
			req_id   <= axi_pkg::ID_INSTR;
			req_addr <= ic_rd_addr;
			req_size <= ic_rd_size;
			req_unc  <= 1'b0;	// instruction fetch is always a line
		end
	end

	assign arvalid = (state == bridge_pkg::RD_ADDR);
	assign arid    = req_id;
	assign araddr  = req_addr;
	assign arsize  = req_size;
	assign arlen   = req_unc ? 4'd0 : 4'(LINE_WORDS - 1);
	assign arburst = req_unc ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR;

	assign rready = (state == bridge_pkg::RD_DATA);
	assign r_beat = rvalid && rready;

	// steer by rid, same cycle
	assign ic_ret_valid = r_beat && (rid == axi_pkg::ID_INSTR);
	assign dc_ret_valid = r_beat && (rid == axi_pkg::ID_DATA);
	assign ic_ret_last  = ic_ret_valid && rlast;
	assign dc_ret_last  = dc_ret_valid && rlast;
	assign ret_data     = rdata;

endmodule

// File: hdl/axi_write_path.sv
`timescale 1ns/1ps

module axi_write_path #(
	parameter int LINE_WORDS = 16
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         dc_wr_req,
	input  logic                         dc_uncached,
	input  logic [axi_pkg::ADDR_W-1:0]   dc_wr_addr,
	input  logic [2:0]                   dc_wr_size,
	input  logic [3:0]                   dc_wr_strb,
	input  logic [LINE_WORDS*32-1:0]     dc_wr_line,
	input  bridge_pkg::word_t            dc_wr_word,
	output logic                         dc_wr_rdy,
	output logic [3:0]                   awid,
	output logic [axi_pkg::ADDR_W-1:0]   awaddr,
	output logic [3:0]                   awlen,
	output logic [2:0]                   awsize,
	output axi_pkg::burst_e              awburst,
	output logic                         awvalid,
	input  logic                         awready,
	output logic [3:0]                   wid,
	output bridge_pkg::word_t            wdata,
	output logic [3:0]                   wstrb,
	output logic                         wlast,
	output logic                         wvalid,
	input  logic                         wready,
	input  logic [1:0]                   bresp,
	input  logic                         bvalid,
	output logic                         bready,
	output logic                         wr_busy,
	output logic [axi_pkg::ADDR_W-1:0]   wr_line_addr
);

	localparam int CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

	bridge_pkg::wr_state_e state, state_nxt;

	logic [axi_pkg::ADDR_W-1:0] addr_q;
	logic [2:0]                 size_q;
	logic [3:0]                 strb_q;
	logic                       unc_q;
	logic [LINE_WORDS*32-1:0]   line_q;	// low word goes out first
	bridge_pkg::word_t          word_q;
	logic [CNT_W-1:0]           beat_cnt;

	logic take;
	logic w_beat;

	assign dc_wr_rdy = (state == bridge_pkg::WR_IDLE);
	assign take      = dc_wr_req && dc_wr_rdy;
	assign w_beat    = wvalid && wready;

	always_comb begin
		state_nxt = state;
		case (state)
			bridge_pkg::WR_IDLE: if (dc_wr_req) state_nxt = bridge_pkg::WR_ADDR;
			bridge_pkg::WR_ADDR: if (awready) state_nxt = bridge_pkg::WR_DATA;
			bridge_pkg::WR_DATA: if (w_beat && wlast) state_nxt = bridge_pkg::WR_RESP;
			bridge_pkg::WR_RESP: if (bvalid) state_nxt = bridge_pkg::WR_IDLE;
			default:             state_nxt = bridge_pkg::WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= bridge_pkg::WR_IDLE;
			beat_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (take)
				beat_cnt <= '0;
			else if (w_beat)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// request capture
	always_ff @(posedge clk) begin
		if (take) begin
			addr_q <= dc_wr_addr;
			size_q <= dc_wr_size;
			strb_q <= dc_wr_strb;
			unc_q  <= dc_uncached;
			word_q <= dc_wr_word;
		end
	end

	// line buffer, shifts only when a beat is taken
	always_ff @(posedge clk) begin
		if (take)
			line_q <= dc_wr_line;
		else if (w_beat)
			line_q <= line_q >> 32;
	end

	// AW channel
	assign awvalid = (state == bridge_pkg::WR_ADDR);
	assign awid    = axi_pkg::ID_DATA;
	assign awaddr  = addr_q;
	assign awsize  = size_q;
	assign awlen   = unc_q ? 4'd0 : 4'(LINE_WORDS - 1);
	assign awburst = unc_q ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR;

	// W channel
	assign wvalid = (state == bridge_pkg::WR_DATA);
	assign wid    = axi_pkg::ID_DATA;
	assign wdata  = unc_q ? word_q : line_q[31:0];
	assign wstrb  = strb_q;
	assign wlast  = unc_q || (beat_cnt == CNT_W'(LINE_WORDS - 1));	// single beat when uncached

	assign bready = (state == bridge_pkg::WR_RESP);

	// seen by the read path for the conflict check
	assign wr_busy      = (state != bridge_pkg::WR_IDLE);
	assign wr_line_addr = addr_q;

endmodule

// File: hdl/axi_cache_bridge.sv
`timescale 1ns/1ps

module axi_cache_bridge #(
	parameter int LINE_WORDS = 16
) (
	input  logic                         clk,
	input  logic                         rst,
	// instruction cache
	input  logic                         ic_rd_req,
	input  logic [axi_pkg::ADDR_W-1:0]   ic_rd_addr,
	input  logic [2:0]                   ic_rd_size,
	output logic                         ic_rd_rdy,
	output logic                         ic_ret_valid,
	output logic                         ic_ret_last,
	output bridge_pkg::word_t            ic_ret_data,
	// data cache
	input  logic                         dc_rd_req,
	input  logic [axi_pkg::ADDR_W-1:0]   dc_rd_addr,
	input  logic [2:0]                   dc_rd_size,
	input  logic                         dc_uncached,	// shared by read and write
	output logic                         dc_rd_rdy,
	output logic                         dc_ret_valid,
	output logic                         dc_ret_last,
	output bridge_pkg::word_t            dc_ret_data,
	input  logic                         dc_wr_req,
	input  logic [axi_pkg::ADDR_W-1:0]   dc_wr_addr,
	input  logic [2:0]                   dc_wr_size,
	input  logic [3:0]                   dc_wr_strb,
	input  logic [LINE_WORDS*32-1:0]     dc_wr_line,
	input  bridge_pkg::word_t            dc_wr_word,
	output logic                         dc_wr_rdy,
	// AXI master
	output logic [3:0]                   arid,
	output logic [axi_pkg::ADDR_W-1:0]   araddr,
	output logic [3:0]                   arlen,
	output logic [2:0]                   arsize,
	output axi_pkg::burst_e              arburst,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic [3:0]                   rid,
	input  bridge_pkg::word_t            rdata,
	input  logic                         rlast,
	input  logic                         rvalid,
	output logic                         rready,
	output logic [3:0]                   awid,
	output logic [axi_pkg::ADDR_W-1:0]   awaddr,
	output logic [3:0]                   awlen,
	output logic [2:0]                   awsize,
	output axi_pkg::burst_e              awburst,
	output logic                         awvalid,
	input  logic                         awready,
	output logic [3:0]                   wid,
	output bridge_pkg::word_t            wdata,
	output logic [3:0]                   wstrb,
	output logic                         wlast,
	output logic                         wvalid,
	input  logic                         wready,
	input  logic                         bvalid,
	output logic                         bready
);

	bridge_pkg::word_t          ret_data;
	logic                       wr_busy;
	logic [axi_pkg::ADDR_W-1:0] wr_line_addr;

	// both caches see the same R data, valid tells them apart
	assign ic_ret_data = ret_data;
	assign dc_ret_data = ret_data;

	axi_read_path #(.LINE_WORDS(LINE_WORDS)) u_read (
		.clk, .rst,
		.ic_rd_req, .ic_rd_addr, .ic_rd_size, .ic_rd_rdy,
		.dc_rd_req, .dc_rd_addr, .dc_rd_size, .dc_uncached, .dc_rd_rdy,
		.ic_ret_valid, .ic_ret_last, .dc_ret_valid, .dc_ret_last,
		.ret_data,
		.wr_busy, .wr_line_addr,	// line conflict hold
		.arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
		.rid, .rdata, .rlast, .rvalid, .rready
	);

	axi_write_path #(.LINE_WORDS(LINE_WORDS)) u_write (
		.clk, .rst,
		.dc_wr_req, .dc_uncached, .dc_wr_addr, .dc_wr_size, .dc_wr_strb,
		.dc_wr_line, .dc_wr_word, .dc_wr_rdy,
		.awid, .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
		.wid, .wdata, .wstrb, .wlast, .wvalid, .wready,
		.bresp(axi_pkg::RESP_OKAY),	// no bresp pin at this level
		.bvalid, .bready,
		.wr_busy, .wr_line_addr
	);

endmodule

// File: test/tb_axi_cache_bridge.sv
`timescale 1ns/1ps

module tb_axi_cache_bridge;

	localparam int LW = 16;
	localparam int LIMIT = 6000;	// ~20 bursts of 16 beats at 4 cycles each, plus margin

	logic clk, rst;
	logic ic_rd_req, ic_rd_rdy, ic_ret_valid, ic_ret_last;
	logic [31:0] ic_rd_addr;
	logic [2:0] ic_rd_size;
	bridge_pkg::word_t ic_ret_data, dc_ret_data, dc_wr_word, rdata, wdata;
	logic dc_rd_req, dc_uncached, dc_rd_rdy, dc_ret_valid, dc_ret_last;
	logic [31:0] dc_rd_addr, dc_wr_addr, araddr, awaddr;
	logic [2:0] dc_rd_size, dc_wr_size, arsize, awsize;
	logic dc_wr_req, dc_wr_rdy;
	logic [3:0] dc_wr_strb, arid, arlen, rid, awid, awlen, wid, wstrb;
	logic [LW*32-1:0] dc_wr_line;
	axi_pkg::burst_e arburst, awburst;
	logic arvalid, arready, rlast, rvalid, rready;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

	bridge_pkg::word_t mem [0:1023];	// slave storage
	bridge_pkg::word_t ref_mem [0:1023];	// expected contents
	logic [32:0] ic_q[$], dc_q[$];	// {last, data} per return beat
	logic [31:0] w_q[$];
	logic [31:0] ar_addr_q[$];
	logic [3:0] ar_id_q[$];
	logic ar_unc_q[$];
	logic [2:0] ar_size_q[$];
	logic [31:0] exp_aw_addr, wr_line;
	logic [2:0] exp_aw_size;
	logic exp_aw_unc, wr_pending, started;
	logic [3:0] exp_strb;
	int errors, cycles;

	// slave state
	logic rd_act, r_taken, wr_aw, b_pend;
	logic [9:0] rd_idx, wr_idx;
	logic [3:0] rd_id;
	int rd_left;

	axi_cache_bridge #(.LINE_WORDS(LW)) axi_cache_bridge_inst (.*);

	initial begin
		clk = 0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] line_word(input logic [31:0] base, input int k);
		return {base[15:0] + 16'(k * 4), 16'h5ee0 ^ 16'(k)};
	endfunction

	// byte lanes with strobe set take the new value
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++)
			if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
		return res;
	endfunction

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	// slave side, handshakes seen at the rising edge
	always @(posedge clk) begin
		r_taken = rvalid && rready;
		if (arvalid && arready) begin
			rd_act = 1;
			rd_idx = araddr[11:2];
			rd_left = arlen + 1;
			rd_id = arid;
		end
		if (rvalid && rready) begin
			rd_left--;
			rd_idx++;
			if (rd_left == 0) rd_act = 0;
		end
		if (awvalid && awready) begin
			wr_aw = 1;
			wr_idx = awaddr[11:2];
		end
		if (wvalid && wready) begin
			mem[wr_idx] = merge_bytes(mem[wr_idx], wdata, wstrb);
			wr_idx++;
			if (wlast) begin
				wr_aw = 0;
				b_pend = 1;
			end
		end
		if (bvalid && bready) b_pend = 0;
	end

	// random stalls, valid held until taken
	always @(negedge clk) begin
		arready = !rd_act && ($urandom % 2);
		if (!rvalid || r_taken) rvalid = rd_act && ($urandom % 3 != 0);
		rdata = mem[rd_idx];
		rlast = (rd_left == 1);
		rid = rd_id;
		awready = !wr_aw && !b_pend && ($urandom % 2);
		wready = wr_aw && ($urandom % 4 != 0);
		bvalid = b_pend && (bvalid || ($urandom % 2));
	end

	always @(posedge clk) begin
		if (rst && !started)
			assert (!arvalid && !rready && !awvalid && !wvalid && !bready && !ic_ret_valid
				&& !dc_ret_valid && dc_wr_rdy)
			else flag_mismatch("outputs not idle after reset");
		// data cache wins a same-cycle request
		if (dc_rd_req)
			assert (!ic_rd_rdy) else flag_mismatch("icache ready while dcache requests");
		if (arvalid && arready) begin
			if (ar_id_q.size() == 0) begin
				flag_mismatch("unexpected AR transfer");
			end else begin
				assert (arid == ar_id_q[0] && araddr == ar_addr_q[0]
					&& arsize == ar_size_q[0]
					&& arlen == (ar_unc_q[0] ? 4'd0 : 4'(LW - 1))
					&& arburst == (ar_unc_q[0] ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR))
				else flag_mismatch($sformatf("AR fields id %0d addr %h len %0d size %0d",
					arid, araddr, arlen, arsize));
				void'(ar_id_q.pop_front());
				void'(ar_addr_q.pop_front());
				void'(ar_unc_q.pop_front());
				void'(ar_size_q.pop_front());
			end
		end
		if (ic_ret_valid) begin
			if (ic_q.size() == 0) begin
				flag_mismatch("unexpected icache return");
			end else begin
				assert (ic_ret_data == ic_q[0][31:0] && ic_ret_last == ic_q[0][32])
				else flag_mismatch($sformatf("icache data %h last %b", ic_ret_data, ic_ret_last));
				void'(ic_q.pop_front());
			end
		end
		if (dc_ret_valid) begin
			if (dc_q.size() == 0) begin
				flag_mismatch("unexpected dcache return");
			end else begin
				assert (dc_ret_data == dc_q[0][31:0] && dc_ret_last == dc_q[0][32])
				else flag_mismatch($sformatf("dcache data %h last %b", dc_ret_data, dc_ret_last));
				void'(dc_q.pop_front());
			end
		end
		if (awvalid && awready)
			assert (awaddr == exp_aw_addr && awlen == (exp_aw_unc ? 4'd0 : 4'(LW - 1))
				&& awsize == exp_aw_size && awid == axi_pkg::ID_DATA
				&& awburst == (exp_aw_unc ? axi_pkg::BURST_FIXED : axi_pkg::BURST_INCR))
			else flag_mismatch($sformatf("AW fields id %0d addr %h len %0d size %0d",
				awid, awaddr, awlen, awsize));
		if (wvalid && wready) begin
			if (w_q.size() == 0) begin
				flag_mismatch("unexpected W beat");
			end else begin
				assert (wdata == w_q[0] && wlast == (w_q.size() == 1) && wstrb == exp_strb
					&& wid == axi_pkg::ID_DATA)
				else flag_mismatch($sformatf("W data %h last %b id %0d", wdata, wlast, wid));
				void'(w_q.pop_front());
			end
		end
		if (wr_pending)
			assert (!dc_wr_rdy) else flag_mismatch("dc_wr_rdy high during write");
		// reads into the line under write must wait for B
		if (wr_pending && dc_rd_req && dc_rd_addr[31:6] == wr_line[31:6])
			assert (!dc_rd_rdy) else flag_mismatch("conflicting read not held");
		if (wr_pending && arvalid && arready && araddr[31:6] == wr_line[31:6])
			flag_mismatch("AR issued into line under write");
		if (bvalid && bready) wr_pending <= 0;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles, %0d errors", LIMIT, errors);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic read_req(input bit dc, input logic [31:0] addr, input bit unc);
		int n;
		@(negedge clk);
		started = 1;
		if (dc) begin
			dc_rd_req = 1;
			dc_rd_addr = addr;
			dc_uncached = unc;
			dc_rd_size = unc ? 3'd0 : 3'd2;	// byte access when uncached
		end else begin
			ic_rd_req = 1;
			ic_rd_addr = addr;
		end
		do @(posedge clk); while (!(dc ? dc_rd_rdy : ic_rd_rdy));
		n = unc ? 1 : LW;
		ar_addr_q.push_back(addr);
		ar_id_q.push_back(dc ? axi_pkg::ID_DATA : axi_pkg::ID_INSTR);
		ar_unc_q.push_back(unc);
		ar_size_q.push_back(dc ? dc_rd_size : ic_rd_size);
		for (int k = 0; k < n; k++) begin
			if (dc) dc_q.push_back({k == n - 1, ref_mem[addr[11:2] + k]});
			else ic_q.push_back({k == n - 1, ref_mem[addr[11:2] + k]});
		end
		@(negedge clk);
		if (dc) begin
			dc_rd_req = 0;
			dc_uncached = 0;
		end else begin
			ic_rd_req = 0;
		end
	endtask

	task automatic write_req(input logic [31:0] addr, input bit unc, input logic [3:0] strb);
		@(negedge clk);
		started = 1;
		dc_wr_req = 1;
		dc_wr_addr = addr;
		dc_uncached = unc;
		dc_wr_strb = strb;
		dc_wr_size = unc ? 3'd1 : 3'd2;
		dc_wr_word = ~addr ^ 32'h1357_9bdf;
		for (int k = 0; k < LW; k++) dc_wr_line[k*32 +: 32] = line_word(addr, k);
		do @(posedge clk); while (!dc_wr_rdy);
		wr_pending <= 1;
		wr_line = addr;
		exp_aw_addr = addr;
		exp_aw_unc = unc;
		exp_aw_size = dc_wr_size;
		exp_strb = strb;
		if (unc) begin
			w_q.push_back(dc_wr_word);
			ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], dc_wr_word, strb);
		end else begin
			for (int k = 0; k < LW; k++) begin
				w_q.push_back(line_word(addr, k));
				ref_mem[addr[11:2] + k] = merge_bytes(ref_mem[addr[11:2] + k],
					line_word(addr, k), strb);
			end
		end
		@(negedge clk);
		dc_wr_req = 0;
		dc_uncached = 0;
	endtask

	task automatic wait_done;
		while (ic_q.size() || dc_q.size() || w_q.size() || wr_pending) @(negedge clk);
	endtask

	initial begin
		void'($urandom(32'h0262b4bf));
		for (int i = 0; i < 1024; i++) begin
			mem[i] = {20'h0, i[9:0], 2'b00} ^ 32'hc3a5_0f96;
			ref_mem[i] = {20'h0, i[9:0], 2'b00} ^ 32'hc3a5_0f96;
		end
		{rst, ic_rd_req, dc_rd_req, dc_uncached, dc_wr_req} = '0;
		{ic_rd_addr, dc_rd_addr, dc_wr_addr, dc_wr_word, dc_wr_line} = '0;
		ic_rd_size = 3'd2;
		dc_rd_size = 3'd2;
		dc_wr_size = 3'd2;
		dc_wr_strb = 4'hf;
		{arready, rvalid, rlast, rdata, rid, awready, wready, bvalid} = '0;
		{rd_act, r_taken, wr_aw, b_pend, rd_idx, wr_idx, rd_id, rd_left} = '0;
		{wr_pending, started, exp_aw_addr, exp_aw_unc, exp_strb, wr_line, exp_aw_size} = '0;
		errors = 0;
		cycles = 0;
		repeat (8) @(posedge clk);
		@(negedge clk) rst = 1;
		repeat (5) @(negedge clk);
		read_req(0, 32'h100, 0);
		wait_done();
		fork
			read_req(1, 32'h204, 1);
			read_req(0, 32'h300, 0);
		join
		wait_done();
		write_req(32'h400, 0, 4'hf);
		wait_done();
		read_req(1, 32'h400, 0);
		wait_done();
		write_req(32'h508, 1, 4'h3);
		wait_done();
		read_req(1, 32'h508, 1);
		wait_done();
		// same line as the write, held until B
		write_req(32'h600, 0, 4'hf);
		read_req(1, 32'h604, 0);
		wait_done();
		write_req(32'h800, 0, 4'hf);
		read_req(0, 32'h700, 0);
		if (!wr_pending) begin
			errors++;
			$display("read to another line was not accepted during the write");
		end
		wait_done();
		repeat (4) @(negedge clk);
		$display("checks done: %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
hdl/axi_pkg.sv
hdl/bridge_pkg.sv
hdl/axi_read_path.sv
hdl/axi_write_path.sv
hdl/axi_cache_bridge.sv
test/tb_axi_cache_bridge.sv

// File: Bender.yml
package:
  name: axi_cache_bridge

sources:
  - files:
      - hdl/axi_pkg.sv
      - hdl/bridge_pkg.sv
      - hdl/axi_read_path.sv
      - hdl/axi_write_path.sv
      - hdl/axi_cache_bridge.sv
  - target: test
    files:
      - test/tb_axi_cache_bridge.sv
